// File: hdl/apb_pkg.sv
package apb_pkg;

	////////////////////
	// Bus structs

	// Requester side of the APB link
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	// Completer side, valid while pready is high
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	////////////////////
	// Register map

	// Control: write bit 0 to update, read bit 0 for busy
	localparam logic [7:0] reg_ctrl       = 8'h00;
	// First pixel word, one word per LED after it
	localparam logic [7:0] reg_pixel_base = 8'h04;

endpackage

// File: hdl/led_pkg.sv
package led_pkg;

	////////////////////
	// Pixel data

	// One LED color, r in the top byte, bit 23 goes out first
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

	// LED position in the chain, up to 256 LEDs
	typedef logic [7:0] led_idx_t;

	////////////////////
	// Framebuffer write port

	// Single-cycle write request from the register block
	typedef struct packed {
		logic     en;
		led_idx_t idx;
		pixel_t   pixel;
	} fb_wr_t;

endpackage

// File: hdl/led_apb_regs.sv
module led_apb_regs
	import apb_pkg::*;
	import led_pkg::*;
#(
	parameter int NUM_LEDS = 8
) (
	input  logic     apb,
	input  logic     rst_n,
	input  apb_req_t req,
	output apb_rsp_t rsp,
	input  logic     busy,
	input  pixel_t   apb_pixel,
	output led_idx_t apb_idx,
	output fb_wr_t   fb_wr,
	output logic     start
);

	logic       access;
	logic       wr_access;
	logic       hit_ctrl;
	logic       hit_pixel;
	logic [7:0] pix_off;

	////////////////////
	// Address decode

	// Access phase, no wait states so pready follows it directly
	assign access    = req.psel && req.penable;
	assign wr_access = access && req.pwrite;

	// Byte offset from the first pixel word
	assign pix_off = req.paddr - reg_pixel_base;

	// Word index into the framebuffer
	assign apb_idx = {2'b00, pix_off[7:2]};

	assign hit_ctrl = req.paddr == reg_ctrl;

	// Pixel hit needs the word aligned, above the base, and below the chain length
	assign hit_pixel = (req.paddr >= reg_pixel_base) &&
		(pix_off[1:0] == 2'b00) &&
		(32'(apb_idx) < NUM_LEDS);

	////////////////////
	// Response path

	always_comb begin
		rsp        = '0;
		rsp.pready = access;
		if (access) begin
			// Unmapped address
			if (!hit_ctrl && !hit_pixel) begin
				rsp.pslverr = 1'b1;
			end else if (!req.pwrite) begin
				if (hit_ctrl)
					rsp.prdata = {31'd0, busy};
				else
					// Readback zero-extended
					rsp.prdata = {8'd0, apb_pixel};
			end
		end
	end

	////////////////////
	// Write side

	always_ff @(posedge apb) begin
		// Payload follows the bus, only en qualifies it
		fb_wr.idx   <= apb_idx;
		// Top byte of pwdata dropped
		fb_wr.pixel <= req.pwdata[23:0];

		if (!rst_n) begin
			fb_wr.en <= 1'b0;
			start    <= 1'b0;
		end else begin
			// One cycle per pixel write
			fb_wr.en <= wr_access && hit_pixel;
			// Update request, one cycle after the access phase
			start    <= wr_access && hit_ctrl && req.pwdata[0];
		end
	end

endmodule

// File: hdl/led_framebuffer.sv
module led_framebuffer
	import led_pkg::*;
#(
	parameter int NUM_LEDS = 8
) (
	input  logic     apb,
	input  logic     rst_n,
	input  fb_wr_t   fb_wr,
	input  led_idx_t apb_idx,
	output pixel_t   apb_pixel,
	input  logic     rd_en,
	input  led_idx_t rd_idx,
	output pixel_t   rd_pixel
);

	// Index bits actually needed for the array
	localparam int IW = (NUM_LEDS > 1) ? $clog2(NUM_LEDS) : 1;

	pixel_t mem [NUM_LEDS];

	////////////////////
	// Storage

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			// All LEDs dark after reset
			for (int i = 0; i < NUM_LEDS; i++)
				mem[i] <= '0;
		end else if (fb_wr.en) begin
			mem[fb_wr.idx[IW-1:0]] <= fb_wr.pixel;
		end
	end

	////////////////////
	// Read ports

	// APB readback, same cycle
	assign apb_pixel = mem[apb_idx[IW-1:0]];

	// Serializer side, loaded at the start of each gap
	always_ff @(posedge apb) begin
		if (rd_en)
			rd_pixel <= mem[rd_idx[IW-1:0]];
	end

endmodule

// File: hdl/led_serializer.sv
module led_serializer
	import led_pkg::*;
#(
	parameter int NUM_LEDS   = 8,
	parameter int SHORT_TIME = 30,
	parameter int LONG_TIME  = 90,
	parameter int IFG_TIME   = 200,
	parameter int RESET_TIME = 750
) (
	input  logic     apb,
	input  logic     rst_n,
	input  logic     start,
	output logic     busy,
	output logic     rd_en,
	output led_idx_t rd_idx,
	input  pixel_t   rd_pixel,
	output logic     led_ctrl
);

	// Counter wide enough for the longest phase
	localparam int MAX_A = (RESET_TIME > IFG_TIME) ? RESET_TIME : IFG_TIME;
	localparam int MAX_B = (LONG_TIME > SHORT_TIME) ? LONG_TIME : SHORT_TIME;
	localparam int MAX_T = (MAX_A > MAX_B) ? MAX_A : MAX_B;
	localparam int CW    = $clog2(MAX_T + 1);

	typedef enum logic [2:0] {
		st_idle,
		st_reset,
		st_gap,
		st_high,
		st_low
	} state_t;

	state_t        state;
	logic [CW-1:0] cnt;
	logic [CW-1:0] len;
	logic [4:0]    bit_idx;
	logic [4:0]    bit_prev;
	led_idx_t      led_idx;
	logic          pending;
	logic          len_done;
	logic          last_led;

	// High time of a bit
	function automatic logic [CW-1:0] high_len(input logic one);
		return one ? CW'(LONG_TIME) : CW'(SHORT_TIME);
	endfunction

	// Low time is the other length, so every bit has the same period
	function automatic logic [CW-1:0] low_len(input logic one);
		return one ? CW'(SHORT_TIME) : CW'(LONG_TIME);
	endfunction

	// Last cycle of the current phase
	assign len_done = cnt == len - 1'b1;
	assign last_led = led_idx == led_idx_t'(NUM_LEDS - 1);
	assign bit_prev = bit_idx - 5'd1;

	assign busy   = state != st_idle;
	assign rd_idx = led_idx;

	////////////////////
	// Line FSM

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			state    <= st_idle;
			cnt      <= '0;
			len      <= '0;
			bit_idx  <= '0;
			led_idx  <= '0;
			pending  <= 1'b0;
			rd_en    <= 1'b0;
			led_ctrl <= 1'b0;
		end else begin
			// Single-cycle strobe
			rd_en <= 1'b0;
			cnt   <= cnt + 1'b1;

			case (state)
				st_idle: begin
					cnt <= '0;
					// Frame request consumed here
					if (pending) begin
						state   <= st_reset;
						len     <= CW'(RESET_TIME);
						pending <= 1'b0;
					end
				end

				// Line held low to latch the chain
				st_reset: if (len_done) begin
					state   <= st_gap;
					cnt     <= '0;
					len     <= CW'(IFG_TIME);
					led_idx <= '0;
					bit_idx <= 5'd23;
					// First pixel fetch
					rd_en   <= 1'b1;
				end

				// Pixel register valid after the first gap cycle
				st_gap: if (len_done) begin
					state    <= st_high;
					cnt      <= '0;
					len      <= high_len(rd_pixel[bit_idx]);
					led_ctrl <= 1'b1;
				end

				st_high: if (len_done) begin
					state    <= st_low;
					cnt      <= '0;
					len      <= low_len(rd_pixel[bit_idx]);
					led_ctrl <= 1'b0;
				end

				st_low: if (len_done) begin
					cnt <= '0;
					if (bit_idx != 5'd0) begin
						// Next bit, MSB first
						state    <= st_high;
						bit_idx  <= bit_prev;
						len      <= high_len(rd_pixel[bit_prev]);
						led_ctrl <= 1'b1;
					end else if (last_led) begin
						// Frame done
						state <= st_idle;
					end else begin
						// Next LED, fetch its pixel during the gap
						state   <= st_gap;
						len     <= CW'(IFG_TIME);
						led_idx <= led_idx + 1'b1;
						bit_idx <= 5'd23;
						rd_en   <= 1'b1;
					end
				end

				default: state <= st_idle;
			endcase

			// A start wins over the clear in idle, extra requests fold into one frame
			if (start)
				pending <= 1'b1;
		end
	end

endmodule

// File: hdl/serial_led_top.sv
module serial_led_top
	import apb_pkg::*;
	import led_pkg::*;
#(
	parameter int NUM_LEDS   = 8,
	// Pulse lengths in apb cycles, defaults for a 100 MHz clock
	parameter int SHORT_TIME = 30,
	parameter int LONG_TIME  = 90,
	parameter int IFG_TIME   = 200,
	parameter int RESET_TIME = 750
) (
	input  logic     apb,
	input  logic     rst_n,
	input  apb_req_t req,
	output apb_rsp_t rsp,
	output logic     led_ctrl
);

	fb_wr_t   fb_wr;
	led_idx_t apb_idx;
	pixel_t   apb_pixel;
	logic     start;
	logic     busy;
	logic     rd_en;
	led_idx_t rd_idx;
	pixel_t   rd_pixel;

	////////////////////
	// Register block

	led_apb_regs #(
		.NUM_LEDS(NUM_LEDS)
	) u_regs (
		.apb      (apb),
		.rst_n    (rst_n),
		.req      (req),
		.rsp      (rsp),
		.busy     (busy),
		.apb_pixel(apb_pixel),
		.apb_idx  (apb_idx),
		.fb_wr    (fb_wr),
		.start    (start)
	);

	////////////////////
	// Pixel storage

	led_framebuffer #(
		.NUM_LEDS(NUM_LEDS)
	) u_fb (
		.apb      (apb),
		.rst_n    (rst_n),
		.fb_wr    (fb_wr),
		.apb_idx  (apb_idx),
		.apb_pixel(apb_pixel),
		.rd_en    (rd_en),
		.rd_idx   (rd_idx),
		.rd_pixel (rd_pixel)
	);

	////////////////////
	// Line driver

	led_serializer #(
		.NUM_LEDS  (NUM_LEDS),
		.SHORT_TIME(SHORT_TIME),
		.LONG_TIME (LONG_TIME),
		.IFG_TIME  (IFG_TIME),
		.RESET_TIME(RESET_TIME)
	) u_ser (
		.apb     (apb),
		.rst_n   (rst_n),
		.start   (start),
		.busy    (busy),
		.rd_en   (rd_en),
		.rd_idx  (rd_idx),
		.rd_pixel(rd_pixel),
		.led_ctrl(led_ctrl)
	);

endmodule

// File: verification/serial_led_assert.sv
module serial_led_assert
	import apb_pkg::*;
(
	input logic     apb,
	input logic     rst_n,
	input logic     busy,
	input logic     led_ctrl,
	input apb_req_t req,
	input apb_rsp_t rsp,
	input logic     start
);
	timeunit 1ns;
	timeprecision 1ps;

	////////////////////
	// Line checks

	// Pulses only inside a frame
	line_in_frame: assert property (@(posedge apb) disable iff (!rst_n) led_ctrl |-> busy)
		else $error("led_ctrl high while the serializer is idle");

	////////////////////
	// APB checks

	err_with_ready: assert property (@(posedge apb) disable iff (!rst_n)
		rsp.pslverr |-> rsp.pready)
		else $error("pslverr without pready");

	// Zero wait states
	ready_in_access: assert property (@(posedge apb) disable iff (!rst_n)
		rsp.pready == (req.psel && req.penable))
		else $error("pready does not follow the access phase");

	start_one_cycle: assert property (@(posedge apb) disable iff (!rst_n) start |=> !start)
		else $error("start held for two cycles");

endmodule

// Serializer instance sees the start pulse but no bus
bind led_serializer serial_led_assert ser_checks (
	.apb     (apb),
	.rst_n   (rst_n),
	.busy    (busy),
	.led_ctrl(led_ctrl),
	.req     ('0),
	.rsp     ('0),
	.start   (start)
);

// Register instance never sees the line
bind led_apb_regs serial_led_assert regs_checks (
	.apb     (apb),
	.rst_n   (rst_n),
	.busy    (busy),
	.led_ctrl(1'b0),
	.req     (req),
	.rsp     (rsp),
	.start   (start)
);

// File: verification/serial_led_tb.sv
module serial_led_tb
	import apb_pkg::*;
	import led_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_leds   = 4;
	localparam int short_time = 2;
	localparam int long_time  = 5;
	localparam int ifg_time   = 8;
	localparam int reset_time = 12;

	// One frame is the reset plus a gap and 24 bit periods per LED
	localparam int frame_cycles = reset_time +
		num_leds * (ifg_time + 24 * (short_time + long_time));
	// Twice four frames plus APB traffic and idle watches
	localparam int timeout_cycles = 2 * (4 * frame_cycles + 136);

	logic     apb;
	logic     rst_n;
	apb_req_t req;
	apb_rsp_t rsp;
	logic     led_ctrl;

	int       mismatches;
	int       failures;
	int       cycles;
	integer   seed;
	// Pixels the line should carry
	pixel_t   expected [num_leds];

	serial_led_top #(
		.NUM_LEDS  (num_leds),
		.SHORT_TIME(short_time),
		.LONG_TIME (long_time),
		.IFG_TIME  (ifg_time),
		.RESET_TIME(reset_time)
	) uut (
		.apb     (apb),
		.rst_n   (rst_n),
		.req     (req),
		.rsp     (rsp),
		.led_ctrl(led_ctrl)
	);

	////////////////////
	// Clock and watchdog

	initial begin
		apb = 1'b0;
		forever #50 apb = ~apb;
	end

	initial begin
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge apb);
			cycles++;
		end
		$display("Timeout after %0d cycles, %0d mismatches and %0d other failures so far",
			cycles, mismatches, failures);
		$display("Simulation failed");
		$finish;
	end

	////////////////////
	// Compare tasks

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
		end
	endtask

	////////////////////
	// APB requester

	// Sample on the edge that closes the access phase
	task automatic bus_cycle(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, input logic exp_err, output logic [31:0] rdata);
		@(posedge apb);
		req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge apb);
		req.penable <= 1'b1;
		@(posedge apb);
		// No wait states expected
		check_flag("pready", rsp.pready, 1'b1);
		check_flag("pslverr", rsp.pslverr, exp_err);
		rdata = rsp.prdata;
		req <= '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata,
			input logic exp_err);
		logic [31:0] unused;
		bus_cycle(1'b1, addr, wdata, exp_err, unused);
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic exp_err,
			output logic [31:0] rdata);
		bus_cycle(1'b0, addr, 32'h0, exp_err, rdata);
	endtask

	// Word address of pixel i
	function automatic logic [7:0] pixel_addr(input int i);
		return 8'(reg_pixel_base + 4 * i);
	endfunction

	////////////////////
	// Line decoder

	// Pulse width picks each of the 24 bits from the MSB down
	task automatic decode_pixel(output pixel_t pix);
		int          width;
		logic [23:0] bits;
		bits = '0;
		for (int i = 0; i < 24; i++) begin
			width = 0;
			while (!led_ctrl)
				@(posedge apb);
			while (led_ctrl) begin
				width++;
				@(posedge apb);
			end
			if (width == long_time)
				bits = {bits[22:0], 1'b1};
			else if (width == short_time)
				bits = {bits[22:0], 1'b0};
			else begin
				failures++;
				$display("Pulse of %0d cycles on led_ctrl is neither a one nor a zero", width);
				bits = {bits[22:0], 1'bx};
			end
		end
		pix = bits;
	endtask

	// Reset gap first and then every LED in chain order
	task automatic receive_frame();
		int     low;
		pixel_t pix;
		low = 0;
		@(posedge apb);
		while (!led_ctrl) begin
			low++;
			@(posedge apb);
		end
		if (low < reset_time) begin
			failures++;
			$display("Line low only %0d cycles before the first bit", low);
		end
		for (int i = 0; i < num_leds; i++) begin
			decode_pixel(pix);
			check_pixel($sformatf("led %0d", i), pix, expected[i]);
		end
	endtask

	task automatic watch_line_low(input int n);
		repeat (n) begin
			@(posedge apb);
			if (led_ctrl) begin
				failures++;
				$display("Line went high with no frame requested");
			end
		end
	endtask

	// Last low pulse is at most long_time cycles
	task automatic confirm_idle();
		logic [31:0] data;
		repeat (long_time) @(posedge apb);
		apb_read(reg_ctrl, 1'b0, data);
		check_flag("busy", data[0], 1'b0);
	endtask

	////////////////////
	// Directed tests

	task automatic idle_after_reset();
		logic [31:0] data;
		watch_line_low(50);
		apb_read(reg_ctrl, 1'b0, data);
		check_word("ctrl", data, 32'h0);
	endtask

	// Top byte written as ones must read back as zero
	task automatic pixel_readback();
		logic [31:0] data;
		logic [31:0] word;
		for (int i = 0; i < num_leds; i++) begin
			word = {8'hff, 8'(8'h10 + i), 8'(8'h80 + 3 * i), 8'(8'hf0 - i)};
			expected[i] = word[23:0];
			apb_write(pixel_addr(i), word, 1'b0);
		end
		for (int i = 0; i < num_leds; i++) begin
			apb_read(pixel_addr(i), 1'b0, data);
			check_word($sformatf("pixel %0d", i), data, {8'h00, expected[i]});
		end
	endtask

	// Pixel 4 and a far address are both unmapped
	task automatic bad_address();
		logic [31:0] data;
		apb_read(8'h14, 1'b1, data);
		apb_read(8'h80, 1'b1, data);
		apb_write(8'h14, 32'h00ab_cdef, 1'b1);
		apb_write(8'h80, 32'h0012_3456, 1'b1);
		for (int i = 0; i < num_leds; i++) begin
			apb_read(pixel_addr(i), 1'b0, data);
			check_word($sformatf("pixel %0d", i), data, {8'h00, expected[i]});
		end
	endtask

	task automatic single_frame();
		logic [31:0] data;
		logic [31:0] word;
		for (int i = 0; i < num_leds; i++) begin
			word = $random(seed);
			expected[i] = word[23:0];
			apb_write(pixel_addr(i), word, 1'b0);
		end
		apb_write(reg_ctrl, 32'h1, 1'b0);
		fork
			receive_frame();
			begin
				// Well inside the reset phase
				repeat (reset_time / 2) @(posedge apb);
				apb_read(reg_ctrl, 1'b0, data);
				check_flag("busy", data[0], 1'b1);
			end
		join
		confirm_idle();
	endtask

	// Two requests mid frame fold into one more frame
	task automatic queued_update();
		apb_write(reg_ctrl, 32'h1, 1'b0);
		fork
			receive_frame();
			begin
				repeat (frame_cycles / 2) @(posedge apb);
				apb_write(reg_ctrl, 32'h1, 1'b0);
				apb_write(reg_ctrl, 32'h1, 1'b0);
			end
		join
		receive_frame();
		confirm_idle();
		watch_line_low(reset_time + ifg_time + long_time);
	endtask

	// Last LED is not loaded yet so the new value goes out
	task automatic rewrite_during_frame();
		logic [31:0] word;
		word = $random(seed);
		apb_write(reg_ctrl, 32'h1, 1'b0);
		fork
			receive_frame();
			begin
				while (!led_ctrl)
					@(posedge apb);
				apb_write(pixel_addr(num_leds - 1), word, 1'b0);
				expected[num_leds - 1] = word[23:0];
			end
		join
		confirm_idle();
	endtask

	////////////////////
	// Sequence

	initial begin
		rst_n      = 1'b0;
		req        = '0;
		mismatches = 0;
		failures   = 0;
		seed       = 90;
		repeat (5) @(posedge apb);
		rst_n <= 1'b1;

		idle_after_reset();
		pixel_readback();
		bad_address();
		single_frame();
		queued_update();
		rewrite_during_frame();

		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: vlog.f
hdl/apb_pkg.sv
hdl/led_pkg.sv
hdl/led_apb_regs.sv
hdl/led_framebuffer.sv
hdl/led_serializer.sv
hdl/serial_led_top.sv
verification/serial_led_assert.sv
verification/serial_led_tb.sv

// File: Makefile
SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: run

obj_dir/Vserial_led_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f vlog.f --top-module serial_led_tb -Mdir obj_dir

run: obj_dir/Vserial_led_tb
	@out="$$(./obj_dir/Vserial_led_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
